// ==== sim.f ====
hdl/mem_pkg.sv
hdl/load_align.sv
hdl/store_align.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/mem_top.sv
tests/mem_chk.sv
tests/mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_tb \
	-f sim.f --Mdir obj_dir -o mem_tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/mem_tb_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
fi

if echo "$sim_out" | grep -q "^All tests passed$"; then
	exit 0
fi

echo "Some tests failed"
exit 1

// ==== tests/mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_tb;

	import mem_pkg::*;

	localparam int         depth_words = 64;
	localparam addr_t      base_addr   = 64'h8000_0000;
	localparam logic [6:0] opc_store   = 7'b010_0011;
	localparam logic [6:0] opc_alu     = 7'b011_0011;
	localparam logic [6:0] opc_imm     = 7'b001_0011;
	localparam int         n_partial   = 40;
	localparam int         n_variant   = 4;  // 29 loads each
	localparam int         n_other     = 30;
	localparam int         n_stall     = 60;
	localparam int total_ops = depth_words + 4 + 2*n_partial + 29*n_variant + n_other + n_stall;
	localparam int reset_ns  = 10 * 4;

	logic        clk;
	logic        reset;
	mem_in_t     in_item;
	logic        in_valid;
	logic        in_ready;
	mem_out_t    out_item;
	logic        out_valid;
	logic        out_ready;
	fwd_t        fwd;
	logic        stall_en;
	logic [31:0] stim_seed;
	addr_t       pc_cnt;
	logic [7:0]  ref_mem [depth_words*8]; // byte image of the RAM
	mem_out_t    exp_q [$];

	mem_top #(
		.depth_words (depth_words),
		.base_addr   (base_addr)
	) mem_top_i (
		.clk       (clk),
		.reset     (reset),
		.in        (in_item),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out       (out_item),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.fwd       (fwd)
	);

	bind mem_stage mem_chk mem_chk_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.ram_wen   (ram_wen),
		.out       (out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [15:0] rand_stim();
		stim_seed = lcg_step(stim_seed);
		return stim_seed[31:16]; // upper bits since the low ones cycle fast
	endfunction

	function automatic data_t rand_data();
		return {rand_stim(), rand_stim(), rand_stim(), rand_stim()};
	endfunction

	// aligned to 1 << size_log within the first span doublewords
	function automatic addr_t rand_addr(input int size_log, input int span);
		int idx;
		int off;
		idx = int'(rand_stim()) % span;
		off = (int'(rand_stim()) % 8) & ~((1 << size_log) - 1);
		return base_addr + addr_t'(idx * 8 + off);
	endfunction

	function automatic data_t fill_value(input addr_t a);
		return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
	endfunction

	// little endian read of 1, 2, 4 or 8 bytes and its extension
	function automatic data_t ref_load(input addr_t a, input funct3_t f3);
		int   base;
		int   n;
		data_t v;
		base = int'(a - base_addr);
		n = 1 << f3[1:0];
		v = '0;
		if (f3 == 3'b111) begin
			return '0;
		end
		for (int i = n - 1; i >= 0; i--) begin
			v = {v[55:0], ref_mem[base + i]};
		end
		if (!f3[2] && v[n*8-1]) begin
			for (int i = n * 8; i < 64; i++) begin
				v[i] = 1'b1;
			end
		end
		return v;
	endfunction

	function automatic void apply_store(input addr_t a, input funct3_t f3, input data_t d);
		int base;
		base = int'(a - base_addr);
		for (int i = 0; i < (1 << f3[1:0]); i++) begin
			ref_mem[base + i] = d[i*8 +: 8];
		end
	endfunction

	function automatic mem_out_t expect_out(input mem_in_t it);
		mem_out_t e;
		e.pc       = it.pc;
		e.ins      = it.ins;
		e.reg_w_en = it.reg_w_en;
		e.rdest    = it.rdest;
		if (!it.wb_sel) begin
			e.wb_data = it.alu_result;
		end else if (it.ins[6:0] == opc_load) begin
			e.wb_data = ref_load(it.alu_result, it.ins[14:12]);
		end else begin
			e.wb_data = '0;
		end
		return e;
	endfunction

	function automatic mem_in_t make_item(input logic [6:0] opc, input funct3_t f3,
			input logic mw, input logic ws, input logic rw, input addr_t alu, input data_t rt);
		mem_in_t     it;
		logic [31:0] r;
		r = {rand_stim(), rand_stim()};
		it.pc         = '0; // numbered in send
		it.ins        = {r[16:0], f3, r[21:17], opc};
		it.mem_w_en   = mw;
		it.wb_sel     = ws;
		it.reg_w_en   = rw;
		it.rt_data    = rt;
		it.rdest      = r[21:17];
		it.alu_result = alu;
		return it;
	endfunction

	task automatic report_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_out(input mem_out_t got, input mem_out_t exp);
		if (got !== exp) begin
			report_error($sformatf("out pc=%h ins=%h rw=%b rd=%0d wb=%h, expected %h %h %b %0d %h",
				got.pc, got.ins, got.reg_w_en, got.rdest, got.wb_data,
				exp.pc, exp.ins, exp.reg_w_en, exp.rdest, exp.wb_data));
		end
	endtask

	task automatic check_fwd(input fwd_t got, input fwd_t exp);
		if (got !== exp) begin
			report_error($sformatf("fwd rw=%b rd=%0d wb=%h, expected rw=%b rd=%0d wb=%h",
				got.reg_w_en, got.rdest, got.wb_data, exp.reg_w_en, exp.rdest, exp.wb_data));
		end
	endtask

	// starts 1 ns after a rising edge and returns 1 ns after the accepting edge
	task automatic send(input mem_in_t item);
		mem_in_t  it;
		mem_out_t e;
		fwd_t     ef;
		logic     done;
		it = item;
		it.pc = pc_cnt;
		pc_cnt = pc_cnt + 64'd4;
		in_item = it;
		in_valid = 1'b1;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			check_flag(in_ready, out_ready, "in_ready");
			if (in_ready) begin
				e = expect_out(it);
				ef.reg_w_en = it.reg_w_en;
				ef.rdest    = it.rdest;
				ef.wb_data  = e.wb_data;
				check_fwd(fwd, ef);
				exp_q.push_back(e);
				if (it.mem_w_en) begin
					apply_store(it.alu_result, it.ins[14:12], it.rt_data);
				end
				done = 1'b1;
			end
			@(posedge clk);
			#1;
			if (done) begin
				check_flag(out_valid, 1'b1, "out_valid one cycle after transfer");
			end
		end
	endtask

	task automatic store(input addr_t a, input funct3_t f3, input data_t d);
		send(make_item(opc_store, f3, 1'b1, 1'b0, 1'b0, a, d));
	endtask

	task automatic load(input addr_t a, input funct3_t f3);
		send(make_item(opc_load, f3, 1'b0, 1'b1, 1'b1, a, rand_data()));
	endtask

	task automatic run_tests();
		addr_t       a;
		funct3_t     f3;
		logic [15:0] sel;
		for (int i = 0; i < depth_words; i++) begin
			a = base_addr + addr_t'(i * 8);
			store(a, f3_d, fill_value(a));
		end
		for (int k = 0; k < 2; k++) begin
			a = rand_addr(3, depth_words);
			store(a, f3_d, rand_data());
			load(a, f3_d);
		end
		for (int k = 0; k < n_partial; k++) begin
			f3 = funct3_t'(rand_stim() % 16'd3);
			a = rand_addr(int'(f3[1:0]), depth_words);
			store(a, f3, rand_data());
			load({a[63:3], 3'b000}, f3_d);
		end
		for (int k = 0; k < n_variant; k++) begin
			a = rand_addr(3, depth_words);
			for (int f = 0; f < 7; f++) begin
				for (int off = 0; off < 8; off += 1 << (f % 4)) begin
					load(a + addr_t'(off), funct3_t'(f));
				end
			end
		end
		for (int k = 0; k < n_other; k++) begin
			if (rand_stim() % 16'd2 == 16'd0) begin
				send(make_item(opc_alu, funct3_t'(rand_stim()), 1'b0, 1'b0, 1'b1,
					rand_data(), rand_data()));
			end else begin
				send(make_item(opc_imm, funct3_t'(rand_stim()), 1'b0, 1'b1, 1'b1,
					rand_data(), rand_data()));
			end
		end
		stall_en = 1'b1;
		for (int k = 0; k < n_stall; k++) begin
			sel = rand_stim() % 16'd3;
			f3 = funct3_t'(rand_stim() % 16'd7);
			a = rand_addr(int'(f3[1:0]), 4); // few doublewords so that loads hit recent stores
			case (sel)
				16'd0: store(a, {1'b0, f3[1:0]}, rand_data());
				16'd1: load(a, f3);
				default: send(make_item(opc_alu, f3, 1'b0, 1'b0, 1'b1, rand_data(), rand_data()));
			endcase
		end
		in_valid = 1'b0;
		stall_en = 1'b0;
	endtask

	// write-back side toggles ready in stretches of 1 to 4 cycles
	initial begin
		logic [31:0] s;
		int          run;
		s = 32'd23;
		run = 0;
		out_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			if (!stall_en) begin
				out_ready = 1'b1;
			end else if (run > 0) begin
				run--;
			end else begin
				s = lcg_step(s);
				out_ready = ~out_ready;
				run = int'(s[31:30]);
			end
		end
	end

	initial begin
		mem_out_t e;
		forever begin
			@(negedge clk);
			if (!reset && out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					report_error("result on out with none expected");
				end else begin
					e = exp_q.pop_front();
					check_out(out_item, e);
				end
			end
		end
	end

	initial begin
		#(reset_ns + total_ops * 4 * 4);
		$display("timeout: the operations did not complete in time");
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int waited;
		reset = 1'b1;
		in_item = '1;
		in_item.mem_w_en = 1'b0; // busy input during reset that never writes
		in_valid = 1'b1;
		stall_en = 1'b0;
		stim_seed = 32'd23;
		pc_cnt = base_addr;
		waited = 0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		in_valid = 1'b0;
		in_item = '0;
		@(negedge clk);
		check_flag(out_valid, 1'b0, "out_valid after reset");
		check_out(out_item, '0);
		@(posedge clk);
		#1;
		run_tests();
		while (exp_q.size() != 0 && waited < 16) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected results never appeared on out", exp_q.size());
			$display("Some tests failed");
			$fatal(1, "results missing");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tests/mem_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_chk (
	input logic              clk,
	input logic              reset,
	input logic              in_valid,
	input logic              in_ready,
	input logic              out_valid,
	input logic              out_ready,
	input logic              ram_wen,
	input mem_pkg::mem_out_t out
);

	ready_follows: assert property (@(posedge clk) in_ready == out_ready)
		else $error("in_ready differs from out_ready");

	// memory only changes on an accepted store
	write_on_xfer: assert property (@(posedge clk) ram_wen |-> (in_valid && in_ready))
		else $error("RAM write without an input transfer");

	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		!out_ready |=> ($stable(out) && $stable(out_valid)))
		else $error("out changed while write-back stalled");

	clear_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high right after reset");

endmodule

`default_nettype wire

// ==== hdl/mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_top #(
	parameter int             depth_words = 512,
	parameter mem_pkg::addr_t base_addr   = 64'h8000_0000
) (
	input  logic              clk,
	input  logic              reset,
	input  mem_pkg::mem_in_t  in,
	input  logic              in_valid,
	output logic              in_ready,
	output mem_pkg::mem_out_t out,
	output logic              out_valid,
	input  logic              out_ready,
	output mem_pkg::fwd_t     fwd
);

	import mem_pkg::*;

	addr_t      ram_addr;
	logic       ram_wen;
	data_t      ram_wdata;
	byte_mask_t ram_wmask;
	data_t      ram_rdata;

	mem_stage mem_stage_i (
		.clk       (clk),
		.reset     (reset),
		.in        (in),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out       (out),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.fwd       (fwd),
		.ram_addr  (ram_addr),
		.ram_wen   (ram_wen),
		.ram_wdata (ram_wdata),
		.ram_wmask (ram_wmask),
		.ram_rdata (ram_rdata)
	);

	data_ram #(
		.depth_words (depth_words),
		.base_addr   (base_addr)
	) data_ram_i (
		.clk   (clk),
		.addr  (ram_addr),
		.wen   (ram_wen),
		.wdata (ram_wdata),
		.wmask (ram_wmask),
		.rdata (ram_rdata)
	);

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  logic                clk,
	input  logic                reset,
	input  mem_pkg::mem_in_t    in,
	input  logic                in_valid,
	output logic                in_ready,
	output mem_pkg::mem_out_t   out,
	output logic                out_valid,
	input  logic                out_ready,
	output mem_pkg::fwd_t       fwd,
	output mem_pkg::addr_t      ram_addr,
	output logic                ram_wen,
	output mem_pkg::data_t      ram_wdata,
	output mem_pkg::byte_mask_t ram_wmask,
	input  mem_pkg::data_t      ram_rdata
);

	import mem_pkg::*;

	logic [6:0] opcode;
	funct3_t    funct3;
	logic [2:0] offset;
	logic       xfer;
	data_t      ldata;
	data_t      wb_data;

	assign opcode = in.ins[6:0];
	assign funct3 = in.ins[14:12];
	assign offset = in.alu_result[2:0];

	// single slot, moves only when write-back takes it
	assign in_ready = out_ready;
	assign xfer     = in_valid & in_ready;

	store_align store_align_i (
		.funct3  (funct3),
		.offset  (offset),
		.rt_data (in.rt_data),
		.wdata   (ram_wdata),
		.wmask   (ram_wmask)
	);

	load_align load_align_i (
		.funct3 (funct3),
		.offset (offset),
		.rdata  (ram_rdata),
		.ldata  (ldata)
	);

	assign ram_addr = in.alu_result;
	assign ram_wen  = xfer & in.mem_w_en; // no write while stalled

	always_comb begin
		if (!in.wb_sel) begin
			wb_data = in.alu_result;
		end else if (opcode == opc_load) begin
			wb_data = ldata;
		end else begin
			wb_data = '0;
		end
	end

	// hazard logic sees the result in the same cycle
	assign fwd.reg_w_en = in.reg_w_en;
	assign fwd.rdest    = in.rdest;
	assign fwd.wb_data  = wb_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (out_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out <= '0;
		end else if (xfer) begin
			out.pc       <= in.pc;
			out.ins      <= in.ins;
			out.reg_w_en <= in.reg_w_en;
			out.rdest    <= in.rdest;
			out.wb_data  <= wb_data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
	parameter int             depth_words = 512,
	parameter mem_pkg::addr_t base_addr   = 64'h8000_0000
) (
	input  logic                clk,
	input  mem_pkg::addr_t      addr,
	input  logic                wen,
	input  mem_pkg::data_t      wdata,
	input  mem_pkg::byte_mask_t wmask,
	output mem_pkg::data_t      rdata
);

	import mem_pkg::*;

	localparam int idx_w = $clog2(depth_words);

	data_t mem [depth_words];

	addr_t            rel_addr;
	logic [idx_w-1:0] idx;

	assign rel_addr = addr - base_addr;
	assign idx      = rel_addr[idx_w+2:3]; // doubleword index

	assign rdata = mem[idx];

	// byte-masked write, wen already qualified by the stage
	always_ff @(posedge clk) begin
		if (wen) begin
			for (int i = 0; i < xlen/8; i++) begin
				if (wmask[i]) begin
					mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align (
	input  mem_pkg::funct3_t   funct3,
	input  logic [2:0]         offset,
	input  mem_pkg::data_t     rt_data,
	output mem_pkg::data_t     wdata,
	output mem_pkg::byte_mask_t wmask
);

	import mem_pkg::*;

	// low two bits of funct3 give the size, the mask picks the lane
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				wdata = {(xlen/8){rt_data[7:0]}};
				wmask = byte_mask_t'(8'b0000_0001) << offset;
			end
			2'b01: begin
				wdata = {(xlen/16){rt_data[15:0]}};
				wmask = byte_mask_t'(8'b0000_0011) << {offset[2:1], 1'b0};
			end
			2'b10: begin
				wdata = {(xlen/32){rt_data[31:0]}};
				wmask = byte_mask_t'(8'b0000_1111) << {offset[2], 2'b00};
			end
			default: begin
				wdata = rt_data; // sd
				wmask = '1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align (
	input  mem_pkg::funct3_t funct3,
	input  logic [2:0]       offset,
	input  mem_pkg::data_t   rdata,
	output mem_pkg::data_t   ldata
);

	import mem_pkg::*;

	data_t b_lane;
	data_t h_lane;
	data_t w_lane;

	// bring the addressed lane down to bit 0
	assign b_lane = rdata >> {offset, 3'b000};
	assign h_lane = rdata >> {offset[2:1], 4'b0000};
	assign w_lane = rdata >> {offset[2], 5'b00000};

	always_comb begin
		case (funct3)
			f3_b: begin
				ldata = {{(xlen-8){b_lane[7]}}, b_lane[7:0]};
			end
			f3_h: begin
				ldata = {{(xlen-16){h_lane[15]}}, h_lane[15:0]};
			end
			f3_w: begin
				ldata = {{(xlen-32){w_lane[31]}}, w_lane[31:0]};
			end
			f3_d: begin
				ldata = rdata; // whole doubleword
			end
			f3_bu: begin
				ldata = {{(xlen-8){1'b0}}, b_lane[7:0]};
			end
			f3_hu: begin
				ldata = {{(xlen-16){1'b0}}, h_lane[15:0]};
			end
			f3_wu: begin
				ldata = {{(xlen-32){1'b0}}, w_lane[31:0]};
			end
			default: begin
				ldata = '0; // no load with funct3 111
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	localparam int xlen = 64;

	typedef logic [xlen-1:0]   addr_t;
	typedef logic [xlen-1:0]   data_t;
	typedef logic [31:0]       ins_t;
	typedef logic [4:0]        reg_idx_t;
	typedef logic [xlen/8-1:0] byte_mask_t; // one bit per byte lane
	typedef logic [2:0]        funct3_t;

	localparam logic [6:0] opc_load = 7'b000_0011;

	localparam funct3_t f3_b  = 3'b000;
	localparam funct3_t f3_h  = 3'b001;
	localparam funct3_t f3_w  = 3'b010;
	localparam funct3_t f3_d  = 3'b011;
	localparam funct3_t f3_bu = 3'b100;
	localparam funct3_t f3_hu = 3'b101;
	localparam funct3_t f3_wu = 3'b110;

	// bundle from execute
	typedef struct packed {
		addr_t    pc;
		ins_t     ins;
		logic     mem_w_en;   // store
		logic     wb_sel;     // 0 alu result, 1 memory data
		logic     reg_w_en;
		data_t    rt_data;    // store source
		reg_idx_t rdest;
		data_t    alu_result; // address for loads and stores
	} mem_in_t;

	typedef struct packed {
		addr_t    pc;
		ins_t     ins;
		logic     reg_w_en;
		reg_idx_t rdest;
		data_t    wb_data;
	} mem_out_t;

	typedef struct packed {
		logic     reg_w_en;
		reg_idx_t rdest;
		data_t    wb_data;
	} fwd_t;

endpackage

`default_nettype wire
